// ==== include/ecc_defs.svh ====
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// codeword layout, low to high:
//   [par-2:0]        hamming check bits
//   [par-1]          overall parity bit
//   [info+par-1:par] info bits
//   above            zero padding

// slot of the overall parity bit, just under the info field
`define ECC_OVERALL_IDX(pw) ((pw) - 1)

// first info bit in the codeword
`define ECC_INFO_LO(pw) (pw)

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the codec testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_ecc_codec -Mdir obj_dir -o tb_ecc_codec -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ecc_codec
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0

// ==== sim.f ====
+incdir+include
source/ecc_pkg.sv
source/ecc_ctrl_if.sv
source/ecc_ctrl.sv
source/ecc_check_gen.sv
source/ecc_overall_parity.sv
source/ecc_decoder.sv
source/ecc_codec_top.sv
testbench/tb_clk_gen.sv
testbench/ecc_codec_assert.sv
testbench/tb_ecc_codec.sv

// ==== source/ecc_check_gen.sv ====
`timescale 1ns/1ns

// encoder stage 1: info placement and hamming check bits
module ecc_check_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         enc_mode,
    input  ecc_pkg::info_t     enc_info,
    ecc_ctrl_if.dp             ctl,
    output ecc_pkg::codeword_t s1_word
);

    int unsigned        par_w;      // parity width of the incoming word
    int unsigned        cw_w;       // codeword width of the registered word
    ecc_pkg::codeword_t placed;     // info shifted above the parity slots
    ecc_pkg::codeword_t chk_cols;   // columns holding check bits
    ecc_pkg::codeword_t built;
    ecc_pkg::codeword_t raw_q;
    ecc_pkg::codeword_t width_mask;

    always_comb begin
        par_w  = ecc_pkg::par_width_tab[enc_mode];
        placed = ecc_pkg::codeword_t'(enc_info) << par_w;

        // check bits are [par-2:0], overall slot stays out
        if (par_w == 0)
            chk_cols = '0;
        else
            chk_cols = ~(ecc_pkg::codeword_t'('1) << (par_w - 1));

        built = placed;
        for (int r = 0; r < ecc_pkg::chk_rows; r++) begin
            // masks are zero in the check columns and above the width,
            // so only this mode's info bits count
            if (^(placed & ecc_pkg::check_mask_tab[enc_mode][r]))
                built = built | (ecc_pkg::check_mask_tab[enc_mode][r] & chk_cols);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            raw_q <= '0;
        else
            raw_q <= built;     // loads every cycle
    end

    // info bits above the mode's width still sit in raw_q
    // cleared here with the mode that travelled with the word
    assign cw_w = ecc_pkg::info_width_tab[ctl.s1_mode] +
                  ecc_pkg::par_width_tab[ctl.s1_mode];
    assign width_mask = ~(ecc_pkg::codeword_t'('1) << cw_w); // shift by 32 gives all ones
    assign s1_word = raw_q & width_mask;

endmodule

// ==== source/ecc_codec_top.sv ====
`timescale 1ns/1ns

module ecc_codec_top (
    input  logic               clk,
    input  logic               rst,
    // encoder path
    input  logic               enc_valid,
    input  logic [1:0]         enc_mode,
    input  ecc_pkg::info_t     enc_info,
    output logic               enc_out_valid,
    output ecc_pkg::codeword_t enc_codeword,
    // decoder path
    input  logic               dec_valid,
    input  logic [1:0]         dec_mode,
    input  ecc_pkg::codeword_t dec_codeword,
    output logic               dec_out_valid,
    output ecc_pkg::info_t     dec_info,
    output logic               dec_corrected,
    output logic               dec_double_err,
    output logic               mode_err
);

    ecc_ctrl_if         ctl ();
    ecc_pkg::codeword_t s1_word;    // stage 1 -> stage 2

    ecc_ctrl u_ecc_ctrl (
        .clk(clk), .rst(rst),
        .enc_valid(enc_valid), .enc_mode(enc_mode),
        .dec_valid(dec_valid), .dec_mode(dec_mode),
        .mode_err(mode_err), .ctl(ctl)
    );

    ecc_check_gen u_ecc_check_gen (
        .clk(clk), .rst(rst), .enc_mode(enc_mode), .enc_info(enc_info),
        .ctl(ctl), .s1_word(s1_word)
    );

    ecc_overall_parity u_ecc_overall_parity (
        .clk(clk), .rst(rst), .s1_word(s1_word),
        .ctl(ctl), .enc_codeword(enc_codeword)
    );

    ecc_decoder u_ecc_decoder (
        .clk(clk), .rst(rst), .dec_mode(dec_mode), .dec_codeword(dec_codeword),
        .ctl(ctl), .dec_info(dec_info),
        .dec_corrected(dec_corrected), .dec_double_err(dec_double_err)
    );

    assign enc_out_valid = ctl.s2_valid;    // two stages after enc_valid
    assign dec_out_valid = ctl.dec_valid_q; // one stage after dec_valid

endmodule

// ==== source/ecc_ctrl.sv ====
`timescale 1ns/1ns

module ecc_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       enc_valid,
    input  logic [1:0] enc_mode,
    input  logic       dec_valid,
    input  logic [1:0] dec_mode,
    output logic       mode_err,
    ecc_ctrl_if.ctrl   ctl
);

    ecc_pkg::ecc_mode_e  enc_m;
    ecc_pkg::ecc_mode_e  dec_m;
    logic                enc_bad;   // strobe with illegal mode
    logic                dec_bad;
    ecc_pkg::dec_state_e dec_state;

    assign enc_m = ecc_pkg::ecc_mode_e'(enc_mode);
    assign dec_m = ecc_pkg::ecc_mode_e'(dec_mode);

    assign enc_bad = enc_valid && (enc_m == ecc_pkg::mode_bad);
    assign dec_bad = dec_valid && (dec_m == ecc_pkg::mode_bad);

    // decoder has one register stage, its valid is the occupancy
    assign ctl.dec_valid_q = (dec_state == ecc_pkg::dec_busy);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl.s1_valid   <= 1'b0;
            ctl.s1_mode    <= ecc_pkg::mode_bad; // bad mode zeroes the datapath
            ctl.s2_valid   <= 1'b0;
            ctl.s2_mode    <= ecc_pkg::mode_bad;
            ctl.dec_mode_q <= ecc_pkg::mode_bad;
            dec_state      <= ecc_pkg::dec_idle;
            mode_err       <= 1'b0;
        end else begin
            // encoder, two stages
            ctl.s1_valid <= enc_valid && !enc_bad;
            ctl.s1_mode  <= enc_m;
            ctl.s2_valid <= ctl.s1_valid;
            ctl.s2_mode  <= ctl.s1_mode;
            // decoder, one stage
            dec_state      <= (dec_valid && !dec_bad) ? ecc_pkg::dec_busy
                                                      : ecc_pkg::dec_idle;
            ctl.dec_mode_q <= dec_m;
            // one-cycle pulse, either path
            mode_err <= enc_bad || dec_bad;
        end
    end

endmodule

// ==== source/ecc_ctrl_if.sv ====
`timescale 1ns/1ns

// valid/mode of each pipeline register, control -> datapath
interface ecc_ctrl_if;

    logic               s1_valid;    // encoder stage 1 holds a word
    ecc_pkg::ecc_mode_e s1_mode;
    logic               s2_valid;    // encoder stage 2, also the output valid
    ecc_pkg::ecc_mode_e s2_mode;
    logic               dec_valid_q; // decoder output register
    ecc_pkg::ecc_mode_e dec_mode_q;

    modport ctrl (
        output s1_valid, s1_mode,
        output s2_valid, s2_mode,
        output dec_valid_q, dec_mode_q
    );

    modport dp (
        input s1_valid, s1_mode,
        input s2_valid, s2_mode,
        input dec_valid_q, dec_mode_q
    );

endinterface

// ==== source/ecc_decoder.sv ====
`timescale 1ns/1ns

`include "ecc_defs.svh"

// syndrome, SEC correction, DED flag, info extraction
module ecc_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         dec_mode,
    input  ecc_pkg::codeword_t dec_codeword,
    ecc_ctrl_if.dp             ctl,
    output ecc_pkg::info_t     dec_info,
    output logic               dec_corrected,
    output logic               dec_double_err
);

    int unsigned          par_w;
    ecc_pkg::codeword_t   width_mask;
    ecc_pkg::syndrome_t   syn;       // [0] overall, [r+1] H row r+1
    ecc_pkg::syndrome_t   hcol;      // H column under test
    ecc_pkg::codeword_t   fixed;
    logic                 single;
    logic                 double_c;
    ecc_pkg::info_t       info_raw;
    ecc_pkg::info_t       info_q;
    ecc_pkg::info_t       info_mask;
    logic                 corr_q;
    logic                 dbl_q;

    always_comb begin
        par_w      = ecc_pkg::par_width_tab[dec_mode];
        width_mask = ~(ecc_pkg::codeword_t'('1) <<
                       (ecc_pkg::info_width_tab[dec_mode] + par_w));

        syn[0] = ^(dec_codeword & width_mask);      // implicit all-ones row
        for (int r = 0; r < ecc_pkg::chk_rows; r++)
            syn[r+1] = ^(dec_codeword & ecc_pkg::check_mask_tab[dec_mode][r]);

        single   = syn[0];                          // odd weight, one flip
        double_c = !syn[0] && (syn[ecc_pkg::max_par_width-1:1] != '0);

        // flip the column whose H column equals the syndrome
        // zero row part means the overall bit itself
        fixed = dec_codeword;
        hcol  = '0;
        if (single) begin
            for (int c = 0; c < ecc_pkg::cw_width; c++) begin
                hcol[0] = width_mask[c];            // columns past the width never match
                for (int r = 0; r < ecc_pkg::chk_rows; r++)
                    hcol[r+1] = ecc_pkg::check_mask_tab[dec_mode][r][c];
                if (hcol == syn)
                    fixed[c] = ~dec_codeword[c];
            end
        end

        info_raw = ecc_pkg::info_t'(fixed >> `ECC_INFO_LO(par_w));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            info_q <= '0;
            corr_q <= 1'b0;
            dbl_q  <= 1'b0;
        end else begin
            info_q <= info_raw;     // upper bits trimmed on the way out
            corr_q <= single;
            dbl_q  <= double_c;
        end
    end

    // trim to the info width of the registered word
    assign info_mask = ~(ecc_pkg::info_t'('1) << ecc_pkg::info_width_tab[ctl.dec_mode_q]);
    assign dec_info  = info_q & info_mask;

    assign dec_corrected  = corr_q & ctl.dec_valid_q;
    assign dec_double_err = dbl_q & ctl.dec_valid_q;

endmodule

// ==== source/ecc_overall_parity.sv ====
`timescale 1ns/1ns

`include "ecc_defs.svh"

// encoder stage 2: overall parity over the whole word
module ecc_overall_parity (
    input  logic               clk,
    input  logic               rst,
    input  ecc_pkg::codeword_t s1_word,
    ecc_ctrl_if.dp             ctl,
    output ecc_pkg::codeword_t enc_codeword
);

    ecc_pkg::codeword_t word_q;
    logic               overall_q;  // even parity over all codeword bits
    int unsigned        par_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            word_q    <= '0;
            overall_q <= 1'b0;
        end else begin
            word_q    <= s1_word;
            overall_q <= ^s1_word;  // overall slot is still zero here
        end
    end

    assign par_w = ecc_pkg::par_width_tab[ctl.s2_mode];

    always_comb begin
        enc_codeword = word_q;
        if (ctl.s2_mode == ecc_pkg::mode_bad)
            enc_codeword = '0;      // no layout for an illegal mode
        else
            enc_codeword[`ECC_OVERALL_IDX(par_w)] = overall_q;
    end

endmodule

// ==== source/ecc_pkg.sv ====
package ecc_pkg;

    localparam int unsigned cw_width       = 32;  // widest codeword
    localparam int unsigned max_info_width = 26;
    localparam int unsigned max_par_width  = 6;   // check bits + overall bit
    localparam int unsigned chk_rows       = max_par_width - 1; // H rows 1..5

    typedef logic [cw_width-1:0]       codeword_t;
    typedef logic [max_info_width-1:0] info_t;     // right-aligned info
    typedef logic [max_par_width-1:0]  syndrome_t; // bit 0 = overall

    typedef enum logic [1:0] {
        mode_8_4   = 2'd0,
        mode_16_11 = 2'd1,
        mode_32_26 = 2'd2,
        mode_bad   = 2'd3   // no code behind it
    } ecc_mode_e;

    // decoder output register holds a word or not
    typedef enum logic {
        dec_idle = 1'b0,
        dec_busy = 1'b1
    } dec_state_e;

    // indexed by mode, mode_bad gets zero widths
    localparam int unsigned info_width_tab [4] = '{4, 11, 26, 0};
    localparam int unsigned par_width_tab  [4] = '{4, 5, 6, 0};

    // rows 1.. of the zero-padded H matrix, row 0 (all ones) is implicit
    // row r has its single check 1 at column par-2-r
    // unused rows are zero so they drop out of every XOR
    localparam codeword_t check_mask_tab [4][chk_rows] = '{
        '{32'h0000_00E4, 32'h0000_00D2, 32'h0000_00B1,
          32'h0000_0000, 32'h0000_0000},                    // (8,4)
        '{32'h0000_FE08, 32'h0000_F1C4, 32'h0000_CDA2,
          32'h0000_AB61, 32'h0000_0000},                    // (16,11)
        '{32'hFFFE_0010, 32'hFF01_FC08, 32'hF0F1_E384,
          32'hCCCD_9B42, 32'hAAAB_56C1},                    // (32,26)
        '{32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
          32'h0000_0000, 32'h0000_0000}                     // illegal
    };

endpackage

// ==== testbench/ecc_codec_assert.sv ====
`timescale 1ns/1ns

// control-side protocol rules, bound into ecc_ctrl
module ecc_codec_assert (
    input logic clk,
    input logic rst,
    input logic enc_valid,
    input logic enc_bad,
    input logic dec_bad,
    input logic mode_err,
    input logic s1_valid,
    input logic s2_valid,
    input logic dec_valid_q
);

    // an illegal word never shows up as output valid
    a_bad_enc_dropped: assert property (@(posedge clk) disable iff (rst)
        enc_bad |=> !s1_valid ##1 !s2_valid)
        else $error("illegal encoder word reached the encoder output");
    a_bad_dec_dropped: assert property (@(posedge clk) disable iff (rst)
        dec_bad |=> !dec_valid_q && mode_err)
        else $error("illegal decoder word reached the decoder output");

    // fixed encoder latency of two
    a_enc_latency: assert property (@(posedge clk) disable iff (rst)
        (enc_valid && !enc_bad) |=> s1_valid ##1 s2_valid)
        else $error("encoder valid did not arrive two cycles later");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !s2_valid && !dec_valid_q && !mode_err)
        else $error("output valid high right after reset");

endmodule

bind ecc_ctrl ecc_codec_assert u_ecc_codec_assert (
    .clk(clk), .rst(rst), .enc_valid(enc_valid),
    .enc_bad(enc_bad), .dec_bad(dec_bad), .mode_err(mode_err),
    .s1_valid(ctl.s1_valid), .s2_valid(ctl.s2_valid), .dec_valid_q(ctl.dec_valid_q)
);

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ns

// clock and power-on reset for the codec testbench
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);  // two reset cycles
        #1 rst = 1'b0;              // released on the stimulus offset
    end

endmodule

// ==== testbench/tb_ecc_codec.sv ====
`timescale 1ns/1ns

module tb_ecc_codec;

    logic               clk;
    logic               rst;
    logic               enc_valid;
    logic [1:0]         enc_mode;
    ecc_pkg::info_t     enc_info;
    logic               enc_out_valid;
    ecc_pkg::codeword_t enc_codeword;
    logic               dec_valid;
    logic [1:0]         dec_mode;
    ecc_pkg::codeword_t dec_codeword;
    logic               dec_out_valid;
    ecc_pkg::info_t     dec_info;
    logic               dec_corrected;
    logic               dec_double_err;
    logic               mode_err;
    integer             seed;

    tb_clk_gen u_tb_clk_gen (.clk(clk), .rst(rst));

    ecc_codec_top u_ecc_codec_top (.*);

    // reference encoder, straight from the H rows in the package
    function automatic ecc_pkg::codeword_t ref_encode(input logic [1:0] mode,
                                                      input ecc_pkg::info_t info);
        int unsigned        iw;
        int unsigned        pw;
        ecc_pkg::codeword_t w;
        ecc_pkg::codeword_t row;
        iw = ecc_pkg::info_width_tab[mode];
        pw = ecc_pkg::par_width_tab[mode];
        w  = '0;
        for (int i = 0; i < iw; i++)
            w[pw + i] = info[i];            // info above the parity slots
        for (int r = 0; r < pw - 1; r++) begin
            row = ecc_pkg::check_mask_tab[mode][r];
            for (int c = 0; c < pw - 1; c++)
                if (row[c])
                    w[c] = ^(w & row);      // the row's own check column
        end
        w[pw - 1] = ^w;                     // overall bit, even weight
        return w;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s at %0t", reason, $time);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] want);
        assert (got === want) else begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, want);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic encode_check(input logic [1:0] mode, input ecc_pkg::info_t info);
        int                 lat;
        ecc_pkg::codeword_t want;
        want      = ref_encode(mode, info);
        enc_valid = 1'b1;
        enc_mode  = mode;
        enc_info  = info;
        lat       = 0;
        do begin
            tick();
            enc_valid = 1'b0;               // single strobe
            lat++;
            if (lat > 8)
                stop_with_failure("enc_out_valid never came");
        end while (!enc_out_valid);
        check_eq("encoder latency", lat, 2);
        check_eq("enc_codeword upper bits", enc_codeword >>
                 (ecc_pkg::info_width_tab[mode] + ecc_pkg::par_width_tab[mode]), 0);
        check_eq("enc_codeword", enc_codeword, want);
    endtask

    task automatic decode_check(input logic [1:0] mode, input ecc_pkg::codeword_t cw,
                                input ecc_pkg::info_t want, input logic corr,
                                input logic dbl);
        int lat;
        dec_valid    = 1'b1;
        dec_mode     = mode;
        dec_codeword = cw;
        lat          = 0;
        do begin
            tick();
            dec_valid = 1'b0;
            lat++;
            if (lat > 8)
                stop_with_failure("dec_out_valid never came");
        end while (!dec_out_valid);
        check_eq("decoder latency", lat, 1);
        check_eq("dec_corrected", dec_corrected, corr);
        check_eq("dec_double_err", dec_double_err, dbl);
        if (!dbl)
            check_eq("dec_info", dec_info, want);   // info undefined on double error
    endtask

    task automatic encode_all_modes();
        for (int m = 0; m < 3; m++)
            repeat (8) encode_check(m[1:0], ecc_pkg::info_t'($random(seed)));
    endtask

    // one word per cycle, modes interleaved
    task automatic stream_mixed_modes();
        ecc_pkg::codeword_t want [12];
        for (int i = 0; i < 14; i++) begin
            if (i >= 2) begin
                check_eq("stream enc_out_valid", enc_out_valid, 1);
                check_eq("stream enc_codeword", enc_codeword, want[i-2]);
            end
            enc_valid = (i < 12);
            enc_mode  = 2'(i % 3);
            enc_info  = ecc_pkg::info_t'($random(seed));
            if (i < 12)
                want[i] = ref_encode(enc_mode, enc_info);
            tick();
        end
        check_eq("stream drained enc_out_valid", enc_out_valid, 0);
    endtask

    // clean word, every single flip, every distinct pair
    task automatic decode_with_flips(input logic [1:0] mode);
        ecc_pkg::info_t     info;
        ecc_pkg::codeword_t cw;
        ecc_pkg::codeword_t one;
        int unsigned        w;
        w    = ecc_pkg::info_width_tab[mode] + ecc_pkg::par_width_tab[mode];
        info = ecc_pkg::info_t'($random(seed));
        info = info & ~(ecc_pkg::info_t'('1) << ecc_pkg::info_width_tab[mode]);
        cw   = ref_encode(mode, info);
        decode_check(mode, cw, info, 1'b0, 1'b0);
        for (int a = 0; a < w; a++) begin
            one = cw ^ (ecc_pkg::codeword_t'(1) << a);
            decode_check(mode, one, info, 1'b1, 1'b0);
            for (int b = a + 1; b < w; b++)
                decode_check(mode, one ^ (ecc_pkg::codeword_t'(1) << b), info, 1'b0, 1'b1);
        end
    endtask

    task automatic reject_illegal_mode();
        int n;
        for (int path = 0; path < 2; path++) begin
            enc_valid = (path == 0);
            dec_valid = (path == 1);
            enc_mode  = 2'd3;
            dec_mode  = 2'd3;
            n         = 0;
            do begin
                tick();
                enc_valid = 1'b0;
                dec_valid = 1'b0;
                n++;
                if (n > 8)
                    stop_with_failure("mode_err never pulsed for mode 3");
            end while (!mode_err);
            check_eq("mode_err latency", n, 1);
            check_eq("dec_out_valid on mode 3", dec_out_valid, 0);
            tick();
            check_eq("mode_err pulse width", mode_err, 0);
            check_eq("enc_out_valid on mode 3", enc_out_valid, 0);
        end
        enc_mode = 2'd0;
        dec_mode = 2'd0;
    endtask

    initial begin
        #1000000;
        stop_with_failure("watchdog expired, simulation stalled");
    end

    initial begin
        int n;
        seed         = 32'h19c165eb;
        enc_valid    = 1'b0;
        enc_mode     = 2'd0;
        enc_info     = '0;
        dec_valid    = 1'b0;
        dec_mode     = 2'd0;
        dec_codeword = '0;
        n            = 0;
        do begin
            @(posedge clk);     // rst only moves 1 ns after an edge
            n++;
            if (n > 20)
                stop_with_failure("reset was never released");
        end while (rst);
        #1;
        check_eq("enc_out_valid after reset", enc_out_valid, 0);
        check_eq("dec_out_valid after reset", dec_out_valid, 0);
        check_eq("mode_err after reset", mode_err, 0);
        check_eq("enc_codeword after reset", enc_codeword, 0);
        check_eq("dec_info after reset", dec_info, 0);
        encode_all_modes();
        stream_mixed_modes();
        reject_illegal_mode();
        for (int m = 0; m < 3; m++)
            decode_with_flips(m[1:0]);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
